// ==== sim.f ====
+incdir+.
soc_pkg.sv
reset_debounce.sv
bus_decoder.sv
int_ctrl.sv
base_ram.sv
gpio_leds.sv
tick_timer.sv
soc_top.sv
tb_soc.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SoC bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_soc -f sim.f

./obj_dir/Vtb_soc 2>&1 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "Simulation run passed"
  exit 0
else
  echo "Simulation run failed, see sim.log"
  exit 1
fi

// ==== tb_soc.sv ====
`timescale 1ns/100ps

`include "soc_config.svh"

module tb_soc;

  localparam int ACK_LIMIT = 8;  // Cycles allowed for one bus transfer
  localparam int DW        = `SOC_DAT_W;

  logic                  clk = 1'b0;
  logic                  rst_lck;
  logic                  m_cyc;
  logic                  m_stb;
  logic                  m_we;
  soc_pkg::bus_addr_u    m_adr;
  logic [`SOC_SEL_W-1:0] m_sel;
  logic [DW-1:0]         m_wdat;
  logic [DW-1:0]         m_rdat;
  logic                  m_ack;
  logic                  inta;
  logic                  nmia;
  logic [6:0]            ext_irq;
  logic                  intr;
  logic                  nmi;
  logic [3:0]            sw;
  logic                  key;
  logic [7:0]            leds;

  // Reference model state
  logic [15:0]   lfsr_state;
  logic [DW-1:0] ram_model [`RAM_WORDS];
  logic [7:0]    led_model;
  logic [DW-1:0] tmr_model;
  logic [7:0]    pend_model;

  soc_top soc_top_i (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .m_cyc_i   (m_cyc),
    .m_stb_i   (m_stb),
    .m_we_i    (m_we),
    .m_adr_i   (m_adr),
    .m_sel_i   (m_sel),
    .m_dat_i   (m_wdat),
    .m_dat_o   (m_rdat),
    .m_ack_o   (m_ack),
    .inta_i    (inta),
    .nmia_i    (nmia),
    .ext_irq_i (ext_irq),
    .intr_o    (intr),
    .nmi_o     (nmi),
    .sw_i      (sw),
    .key_i     (key),
    .leds_o    (leds)
  );

  always #50 clk = ~clk;

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic soc_pkg::bus_addr_u mem_adr(input logic [18:0] word);
    soc_pkg::bus_addr_u a;
    a.mem.io   = 1'b0;
    a.mem.word = word;
    return a;
  endfunction

  function automatic soc_pkg::bus_addr_u io_adr(input logic [15:0] port, input logic [3:0] pad);
    soc_pkg::bus_addr_u a;
    a.io.io     = 1'b1;
    a.io.pad    = pad;
    a.io.port_w = port[15:1];
    return a;
  endfunction

  function automatic int lowest_set(input logic [7:0] p);
    for (int i = 0; i < 8; i++) begin
      if (p[i]) return i;
    end
    return 0;
  endfunction

  task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic expect_word(input string name, input logic [DW-1:0] got,
                             input logic [DW-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      stop_on_error();
    end
  endtask

  task automatic verify_leds(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("MISMATCH leds_o: got 0x%h, expected 0x%h at %0t", got, exp, $time);
      stop_on_error();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      stop_on_error();
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic wait_ack();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!m_ack && n < ACK_LIMIT);
    if (!m_ack) begin
      $display("No bus acknowledge within %0d cycles for address 0x%h", ACK_LIMIT, m_adr);
      stop_on_error();
    end
  endtask

  // Request stays up through the ack cycle
  task automatic release_bus();
    @(posedge clk);
    #1;
    m_cyc = 1'b0;
    m_stb = 1'b0;
    m_we  = 1'b0;
    inta  = 1'b0;
    nmia  = 1'b0;
  endtask

  task automatic bus_write(input soc_pkg::bus_addr_u adr, input logic [1:0] sel,
                           input logic [DW-1:0] dat);
    m_cyc  = 1'b1;
    m_stb  = 1'b1;
    m_we   = 1'b1;
    m_adr  = adr;
    m_sel  = sel;
    m_wdat = dat;
    wait_ack();
    release_bus();
  endtask

  task automatic bus_read(input soc_pkg::bus_addr_u adr, input logic ia, input logic na,
                          output logic [DW-1:0] dat);
    m_cyc = 1'b1;
    m_stb = 1'b1;
    m_we  = 1'b0;
    m_adr = adr;
    m_sel = 2'b11;
    inta  = ia;
    nmia  = na;
    wait_ack();
    dat = m_rdat;
    release_bus();
  endtask

  task automatic wait_intr(input int limit, input string what);
    int n;
    n = 0;
    while (!intr && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!intr) begin
      $display("intr_o stayed low for %0d cycles waiting for %s", limit, what);
      stop_on_error();
    end
  endtask

  task automatic wait_nmi(input int limit);
    int n;
    n = 0;
    while (!nmi && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!nmi) begin
      $display("nmi_o did not rise within %0d cycles of the key press", limit);
      stop_on_error();
    end
  endtask

  task automatic ram_test();
    logic [9:0]    idx;
    logic [1:0]    sel;
    logic [DW-1:0] wd;
    logic [DW-1:0] rd;
    // Known contents everywhere before random traffic
    for (int i = 0; i < `RAM_WORDS; i++) begin
      wd = 16'(i * 40503) ^ 16'h5A3C;
      bus_write(mem_adr(19'(i)), 2'b11, wd);
      ram_model[i] = wd;
    end
    for (int n = 0; n < 400; n++) begin
      idx = 10'(rand_bits(10));
      if (rand_bits(1) == 32'd1) begin
        sel = 2'(rand_bits(2));
        wd  = 16'(rand_bits(16));
        bus_write(mem_adr(19'(idx)), sel, wd);
        if (sel[0]) ram_model[idx][7:0] = wd[7:0];
        if (sel[1]) ram_model[idx][15:8] = wd[15:8];
      end else begin
        bus_read(mem_adr(19'(idx)), 1'b0, 1'b0, rd);
        expect_word("m_dat_o ram read", rd, ram_model[idx]);
      end
    end
  endtask

  task automatic unmapped_test();
    logic [18:0]   word;
    logic [15:0]   port;
    logic [3:0]    pad;
    logic [DW-1:0] rd;
    for (int n = 0; n < 20; n++) begin
      word = 19'(rand_bits(19)) | 19'h00400;  // Above the RAM
      bus_read(mem_adr(word), 1'b0, 1'b0, rd);
      expect_word("m_dat_o unmapped mem", rd, '0);
      bus_write(mem_adr(word), 2'b11, 16'(rand_bits(16)));
      bus_read(mem_adr({9'h000, word[9:0]}), 1'b0, 1'b0, rd);
      expect_word("m_dat_o ram after unmapped write", rd, ram_model[word[9:0]]);
      port = {15'(rand_bits(15)), 1'b0};
      if ((port & 16'hFFFC) == 16'hF100 || (port & 16'hFFFC) == 16'h0040) begin
        port = port ^ 16'h8000;  // Move off a mapped port
      end
      pad = 4'(rand_bits(4));
      bus_read(io_adr(port, pad), 1'b0, 1'b0, rd);
      expect_word("m_dat_o unmapped io", rd, '0);
      bus_write(io_adr(port, pad), 2'b11, 16'(rand_bits(16)));
      verify_leds(leds, led_model);
    end
    bus_read(io_adr(16'h0040, 4'h0), 1'b0, 1'b0, rd);
    expect_word("m_dat_o timer reload", rd, tmr_model);
  endtask

  task automatic gpio_test();
    logic [1:0]    sel;
    logic [DW-1:0] wd;
    logic [DW-1:0] rd;
    for (int n = 0; n < 12; n++) begin
      sel = 2'(rand_bits(2));
      wd  = 16'(rand_bits(16));
      bus_write(io_adr(16'hF100, 4'h0), sel, wd);
      if (sel[0]) led_model = wd[7:0];  // LEDs sit in the low byte
      verify_leds(leds, led_model);
      bus_read(io_adr(16'hF100, 4'h0), 1'b0, 1'b0, rd);
      expect_word("m_dat_o led readback", rd, {8'h00, led_model});
      sw = 4'(rand_bits(4));
      bus_read(io_adr(16'hF102, 4'h0), 1'b0, 1'b0, rd);
      expect_word("m_dat_o switch readback", rd, {11'h000, key, sw});
    end
  endtask

  task automatic timer_test();
    logic [DW-1:0] r_val;
    logic [DW-1:0] rd;
    for (int r = 0; r < 3; r++) begin
      r_val = 16'(rand_bits(5)) + 16'd4;  // Period 4 to 35
      bus_write(io_adr(16'h0040, 4'h0), 2'b11, r_val);
      tmr_model = r_val;
      bus_read(io_adr(16'h0040, 4'h0), 1'b0, 1'b0, rd);
      expect_word("m_dat_o timer reload", rd, tmr_model);
      wait_intr(int'(r_val) + 4, "the first timer tick");
      pend_model = 8'h01;
      bus_read(io_adr(16'h0000, 4'h0), 1'b1, 1'b0, rd);
      expect_word("m_dat_o timer vector", rd, 16'(`INT_VEC_BASE + lowest_set(pend_model)));
      pend_model = 8'h00;
      wait_intr(int'(r_val) + 2, "the next timer tick");
      pend_model = 8'h01;
      // Stop the timer before serving the second tick
      bus_write(io_adr(16'h0040, 4'h0), 2'b11, 16'h0000);
      tmr_model = '0;
      idle(2);
      bus_read(io_adr(16'h0000, 4'h0), 1'b1, 1'b0, rd);
      expect_word("m_dat_o timer vector", rd, 16'(`INT_VEC_BASE + lowest_set(pend_model)));
      pend_model = 8'h00;
      check_flag("intr_o", intr, |pend_model);
    end
  endtask

  task automatic ext_irq_test();
    logic [6:0]    mask;
    logic [DW-1:0] rd;
    int            id;
    for (int r = 0; r < 6; r++) begin
      mask = 7'(rand_bits(7));
      if (mask == '0) mask = 7'h40;
      ext_irq    = mask;
      pend_model = {mask, 1'b0};  // Line 0 belongs to the timer
      idle(2);
      for (int k = 0; k < 8 && pend_model != '0; k++) begin
        check_flag("intr_o", intr, 1'b1);
        id = lowest_set(pend_model);
        bus_read(io_adr(16'h0000, 4'h0), 1'b1, 1'b0, rd);
        expect_word("m_dat_o irq vector", rd, 16'(`INT_VEC_BASE + id));
        pend_model[id] = 1'b0;
      end
      check_flag("intr_o", intr, 1'b0);
      ext_irq = '0;
      idle(1);
    end
  endtask

  task automatic nmi_test();
    logic [DW-1:0] rd;
    for (int r = 0; r < 3; r++) begin
      idle(int'(rand_bits(2)) + 1);
      key = 1'b0;  // Press
      wait_nmi(4);
      bus_read(io_adr(16'hF102, 4'h0), 1'b0, 1'b0, rd);
      expect_word("m_dat_o key readback", rd, {11'h000, 1'b0, sw});
      check_flag("nmi_o", nmi, 1'b1);
      bus_read(io_adr(16'h0000, 4'h0), 1'b0, 1'b1, rd);
      expect_word("m_dat_o nmi vector", rd, 16'(`NMI_VEC));
      check_flag("nmi_o", nmi, 1'b0);
      key = 1'b1;
      idle(3);
    end
  endtask

  initial begin
    lfsr_state = 16'd50346;
    rst_lck    = 1'b0;
    m_cyc      = 1'b0;
    m_stb      = 1'b0;
    m_we       = 1'b0;
    m_adr      = '0;
    m_sel      = '0;
    m_wdat     = '0;
    inta       = 1'b0;
    nmia       = 1'b0;
    ext_irq    = '0;
    sw         = '0;
    key        = 1'b1;  // Released
    led_model  = '0;
    tmr_model  = '0;
    pend_model = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_lck = 1'b1;
    idle(`DEBOUNCE_CYCLES + 4);
    check_flag("m_ack_o", m_ack, 1'b0);
    check_flag("intr_o", intr, 1'b0);
    check_flag("nmi_o", nmi, 1'b0);
    verify_leds(leds, led_model);
    ram_test();
    unmapped_test();
    gpio_test();
    timer_test();
    ext_irq_test();
    nmi_test();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// ==== soc_top.sv ====
`timescale 1ns/100ps

`include "soc_config.svh"

module soc_top (
  input  logic                  clk,
  input  logic                  rst_lck,
  input  logic                  m_cyc_i,
  input  logic                  m_stb_i,
  input  logic                  m_we_i,
  input  soc_pkg::bus_addr_u    m_adr_i,
  input  logic [`SOC_SEL_W-1:0] m_sel_i,
  input  logic [`SOC_DAT_W-1:0] m_dat_i,
  output logic [`SOC_DAT_W-1:0] m_dat_o,
  output logic                  m_ack_o,
  input  logic                  inta_i,
  input  logic                  nmia_i,
  input  logic [6:0]            ext_irq_i,
  output logic                  intr_o,
  output logic                  nmi_o,
  input  logic [3:0]            sw_i,
  input  logic                  key_i,
  output logic [7:0]            leds_o
);

  logic                  sys_rst_n;
  logic                  ram_stb;
  logic                  ram_ack;
  logic [`SOC_DAT_W-1:0] ram_dat;
  logic                  gpio_stb;
  logic                  gpio_ack;
  logic [`SOC_DAT_W-1:0] gpio_dat;
  logic                  tmr_stb;
  logic                  tmr_ack;
  logic [`SOC_DAT_W-1:0] tmr_dat;
  logic [`SOC_DAT_W-1:0] bus_dat;
  logic                  tick;

  reset_debounce reset_debounce_i (
    .clk         (clk),
    .rst_lck     (rst_lck),
    .sys_rst_n_o (sys_rst_n)
  );

  bus_decoder bus_decoder_i (
    .clk        (clk),
    .rst_n_i    (sys_rst_n),
    .m_cyc_i    (m_cyc_i),
    .m_stb_i    (m_stb_i),
    .m_adr_i    (m_adr_i),
    .ram_ack_i  (ram_ack),
    .ram_dat_i  (ram_dat),
    .gpio_ack_i (gpio_ack),
    .gpio_dat_i (gpio_dat),
    .tmr_ack_i  (tmr_ack),
    .tmr_dat_i  (tmr_dat),
    .ram_stb_o  (ram_stb),
    .gpio_stb_o (gpio_stb),
    .tmr_stb_o  (tmr_stb),
    .m_ack_o    (m_ack_o),
    .bus_dat_o  (bus_dat)
  );

  // Timer tick on line 0, external lines above it
  int_ctrl int_ctrl_i (
    .clk       (clk),
    .rst_n_i   (sys_rst_n),
    .irq_i     ({ext_irq_i, tick}),
    .inta_i    (inta_i),
    .nmia_i    (nmia_i),
    .m_ack_i   (m_ack_o),
    .bus_dat_i (bus_dat),
    .intr_o    (intr_o),
    .m_dat_o   (m_dat_o)
  );

  base_ram base_ram_i (
    .clk     (clk),
    .rst_n_i (sys_rst_n),
    .stb_i   (ram_stb),
    .we_i    (m_we_i),
    .adr_i   (m_adr_i),
    .sel_i   (m_sel_i),
    .dat_i   (m_dat_i),
    .dat_o   (ram_dat),
    .ack_o   (ram_ack)
  );

  gpio_leds gpio_leds_i (
    .clk     (clk),
    .rst_n_i (sys_rst_n),
    .stb_i   (gpio_stb),
    .we_i    (m_we_i),
    .adr_i   (m_adr_i),
    .sel_i   (m_sel_i),
    .dat_i   (m_dat_i),
    .sw_i    (sw_i),
    .key_i   (key_i),
    .nmia_i  (nmia_i),
    .m_ack_i (m_ack_o),
    .dat_o   (gpio_dat),
    .ack_o   (gpio_ack),
    .leds_o  (leds_o),
    .nmi_o   (nmi_o)
  );

  tick_timer tick_timer_i (
    .clk     (clk),
    .rst_n_i (sys_rst_n),
    .stb_i   (tmr_stb),
    .we_i    (m_we_i),
    .adr_i   (m_adr_i),
    .sel_i   (m_sel_i),
    .dat_i   (m_dat_i),
    .dat_o   (tmr_dat),
    .ack_o   (tmr_ack),
    .tick_o  (tick)
  );

endmodule

// ==== tick_timer.sv ====
`timescale 1ns/100ps

`include "soc_config.svh"

module tick_timer (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  soc_pkg::bus_addr_u    adr_i,
  input  logic [`SOC_SEL_W-1:0] sel_i,
  input  logic [`SOC_DAT_W-1:0] dat_i,
  output logic [`SOC_DAT_W-1:0] dat_o,
  output logic                  ack_o,
  output logic                  tick_o
);

  logic                  cnt_port;  // Port 0x42 selected
  logic                  wr_reload;
  logic [`SOC_DAT_W-1:0] reload;
  logic [`SOC_DAT_W-1:0] new_reload;
  logic [`SOC_DAT_W-1:0] cnt;

  assign cnt_port  = adr_i.io.port_w[0];
  assign wr_reload = stb_i & we_i & !ack_o & !cnt_port;

  // Byte-merged reload value
  always_comb begin
    new_reload = reload;
    for (int b = 0; b < `SOC_SEL_W; b++) begin
      if (sel_i[b]) begin
        new_reload[8*b +: 8] = dat_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_o  <= 1'b0;
      reload <= '0;
      cnt    <= '0;
      tick_o <= 1'b0;
    end else begin
      ack_o <= stb_i & !ack_o;
      if (wr_reload) begin
        reload <= new_reload;
        cnt    <= new_reload;  // Restart from the new period
        tick_o <= 1'b0;
      end else if (reload != '0) begin
        if (cnt <= `SOC_DAT_W'(1)) begin
          cnt    <= reload;
          tick_o <= 1'b1;
        end else begin
          cnt    <= cnt - 1'b1;
          tick_o <= 1'b0;
        end
      end else begin
        tick_o <= 1'b0;  // Stopped
      end
    end
  end

  always_ff @(posedge clk) begin
    dat_o <= cnt_port ? cnt : reload;
  end

endmodule

// ==== gpio_leds.sv ====
`timescale 1ns/100ps

`include "soc_config.svh"

module gpio_leds (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  soc_pkg::bus_addr_u    adr_i,
  input  logic [`SOC_SEL_W-1:0] sel_i,
  input  logic [`SOC_DAT_W-1:0] dat_i,
  input  logic [3:0]            sw_i,
  input  logic                  key_i,
  input  logic                  nmia_i,
  input  logic                  m_ack_i,
  output logic [`SOC_DAT_W-1:0] dat_o,
  output logic                  ack_o,
  output logic [7:0]            leds_o,
  output logic                  nmi_o
);

  logic       sw_port;  // Port 0xF102 selected
  logic [1:0] key_q;
  logic       key_fall;

  assign sw_port  = adr_i.io.port_w[0];
  assign key_fall = key_q[1] & !key_q[0];  // Pushbutton is active low

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_o  <= 1'b0;
      leds_o <= '0;
      key_q  <= 2'b11;
      nmi_o  <= 1'b0;
    end else begin
      ack_o <= stb_i & !ack_o;
      if (stb_i && we_i && !ack_o && !sw_port && sel_i[0]) begin
        leds_o <= dat_i[7:0];
      end
      key_q <= {key_q[0], key_i};
      if (key_fall) begin
        nmi_o <= 1'b1;
      end else if (nmia_i && m_ack_i) begin
        nmi_o <= 1'b0;  // NMI served
      end
    end
  end

  // Readback
  always_ff @(posedge clk) begin
    if (sw_port) begin
      dat_o <= `SOC_DAT_W'({key_q[1], sw_i});
    end else begin
      dat_o <= `SOC_DAT_W'(leds_o);
    end
  end

endmodule

// ==== base_ram.sv ====
`timescale 1ns/100ps

`include "soc_config.svh"

module base_ram (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  stb_i,
  input  logic                  we_i,
  input  soc_pkg::bus_addr_u    adr_i,
  input  logic [`SOC_SEL_W-1:0] sel_i,
  input  logic [`SOC_DAT_W-1:0] dat_i,
  output logic [`SOC_DAT_W-1:0] dat_o,
  output logic                  ack_o
);

  localparam int IDX_W = $clog2(`RAM_WORDS);

  logic [`SOC_DAT_W-1:0] mem [`RAM_WORDS];
  logic [IDX_W-1:0]      idx;

  assign idx = adr_i.mem.word[IDX_W-1:0];

  always_ff @(posedge clk) begin
    if (stb_i && we_i && !ack_o) begin
      for (int b = 0; b < `SOC_SEL_W; b++) begin
        if (sel_i[b]) begin
          mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
    dat_o <= mem[idx];  // Read data lines up with ack
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i & !ack_o;
    end
  end

  // Master holds the strobe through the ack cycle
  a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
    ack_o |-> stb_i);

endmodule

// ==== int_ctrl.sv ====
`timescale 1ns/100ps

`include "soc_config.svh"

module int_ctrl (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic [`SOC_IRQ_N-1:0] irq_i,
  input  logic                  inta_i,
  input  logic                  nmia_i,
  input  logic                  m_ack_i,
  input  logic [`SOC_DAT_W-1:0] bus_dat_i,
  output logic                  intr_o,
  output logic [`SOC_DAT_W-1:0] m_dat_o
);

  localparam int IID_W = $clog2(`SOC_IRQ_N);
  localparam int DW    = `SOC_DAT_W;

  logic [`SOC_IRQ_N-1:0] irq_q;
  logic [`SOC_IRQ_N-1:0] pend;
  logic [`SOC_IRQ_N-1:0] served;
  logic [IID_W-1:0]      iid;

  // Lowest pending line has priority
  always_comb begin
    iid = '0;
    for (int i = `SOC_IRQ_N - 1; i >= 0; i--) begin
      if (pend[i]) begin
        iid = IID_W'(i);
      end
    end
  end

  assign served = (inta_i & m_ack_i) ? (`SOC_IRQ_N'(1) << iid) : '0;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      irq_q <= '0;
      pend  <= '0;
    end else begin
      irq_q <= irq_i;
      pend  <= (pend & ~served) | (irq_i & ~irq_q);  // New edge is never lost
    end
  end

  assign intr_o = |pend;

  // Vector substitution on the read path
  assign m_dat_o = nmia_i ? DW'(`NMI_VEC) :
                   inta_i ? DW'(`INT_VEC_BASE) + DW'(iid) :
                   bus_dat_i;

  // Chosen id is pending and no lower line is
  a_iid_pending: assert property (@(posedge clk) disable iff (!rst_n_i)
    intr_o |-> pend[iid] &&
               ((pend & ((`SOC_IRQ_N'(1) << iid) - `SOC_IRQ_N'(1))) == '0));

endmodule

// ==== bus_decoder.sv ====
`timescale 1ns/100ps

`include "soc_config.svh"

module bus_decoder (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  m_cyc_i,
  input  logic                  m_stb_i,
  input  soc_pkg::bus_addr_u    m_adr_i,
  input  logic                  ram_ack_i,
  input  logic [`SOC_DAT_W-1:0] ram_dat_i,
  input  logic                  gpio_ack_i,
  input  logic [`SOC_DAT_W-1:0] gpio_dat_i,
  input  logic                  tmr_ack_i,
  input  logic [`SOC_DAT_W-1:0] tmr_dat_i,
  output logic                  ram_stb_o,
  output logic                  gpio_stb_o,
  output logic                  tmr_stb_o,
  output logic                  m_ack_o,
  output logic [`SOC_DAT_W-1:0] bus_dat_o
);

  logic req;
  logic gpio_hit;
  logic tmr_hit;
  logic ram_hit;
  logic def_hit;
  logic def_ack;

  assign req = m_cyc_i & m_stb_i;

  // Each slave matches on its own base and mask
  assign gpio_hit = ((m_adr_i & `GPIO_MASK) == `GPIO_BASE);
  assign tmr_hit  = ((m_adr_i & `TIMER_MASK) == `TIMER_BASE);
  assign ram_hit  = ((m_adr_i & `RAM_MASK) == `RAM_BASE);
  assign def_hit  = !(gpio_hit | tmr_hit | ram_hit);

  assign ram_stb_o  = req & ram_hit;
  assign gpio_stb_o = req & gpio_hit;
  assign tmr_stb_o  = req & tmr_hit;

  // Default slave acks anything unmapped with zero data
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      def_ack <= 1'b0;
    end else begin
      def_ack <= req & def_hit & !def_ack;
    end
  end

  assign m_ack_o = ram_ack_i | gpio_ack_i | tmr_ack_i | def_ack;

  // Return data follows the address held by the master
  always_comb begin
    if (ram_hit) begin
      bus_dat_o = ram_dat_i;
    end else if (gpio_hit) begin
      bus_dat_o = gpio_dat_i;
    end else if (tmr_hit) begin
      bus_dat_o = tmr_dat_i;
    end else begin
      bus_dat_o = '0;
    end
  end

  // Overlapping windows in the map would raise two strobes
  a_one_stb: assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0({ram_stb_o, gpio_stb_o, tmr_stb_o}));

  // Every ack, from any slave, answers a request seen one edge earlier
  a_ack_after_req: assert property (@(posedge clk) disable iff (!rst_n_i)
    m_ack_o |-> $past(req));

endmodule

// ==== reset_debounce.sv ====
`timescale 1ns/100ps

`include "soc_config.svh"

module reset_debounce (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_n_o
);

  localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

  logic [CNT_W-1:0] cnt;

  // Counter reloads for as long as the raw reset is held
  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt         <= CNT_W'(`DEBOUNCE_CYCLES);
      sys_rst_n_o <= 1'b0;
    end else begin
      if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end
      sys_rst_n_o <= (cnt == '0);  // Released once fully counted out
    end
  end

endmodule

// ==== soc_pkg.sv ====
package soc_pkg;

`include "soc_config.svh"

  // One tagged bus address word, read two ways by the slaves.
  // Memory slaves index with the full word address, I/O slaves
  // only look at the low port bits and ignore the pad.
  typedef union packed {
    struct packed {
      logic                  io;    // Clear in memory space
      logic [`SOC_ADR_W-2:0] word;  // Byte address divided by 2
    } mem;
    struct packed {
      logic                   io;     // Set in I/O space
      logic [`SOC_ADR_W-17:0] pad;    // Not decoded
      logic [14:0]            port_w; // Port number divided by 2
    } io;
  } bus_addr_u;

endpackage

// ==== soc_config.svh ====
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Bus widths
`define SOC_DAT_W 16
`define SOC_ADR_W 20  // I/O tag bit on top of a 19-bit word address
`define SOC_SEL_W 2
`define SOC_IRQ_N 8

// Base RAM at memory bytes 0x00000 to 0x007FF
`define RAM_WORDS 1024
`define RAM_BASE  20'h00000
`define RAM_MASK  20'hFFC00  // Tag bit plus word address bits 18:10

// I/O ports compare the tag and the low 15 word address bits only
`define GPIO_BASE  20'h87880  // Ports 0xF100 to 0xF103
`define GPIO_MASK  20'h87FFE

`define TIMER_BASE 20'h80020  // Ports 0x40 to 0x43
`define TIMER_MASK 20'h87FFE

// Reset stretch in clk cycles
`define DEBOUNCE_CYCLES 16

// Vectors returned during acknowledge cycles
`define INT_VEC_BASE 8
`define NMI_VEC      2

`endif
